// ==== common/mem_pkg.sv ====
package mem_pkg;

  // the AXI-Lite side is byte addressed
  localparam int AXIL_ADDR_W = 12;
  localparam int DATA_W      = 32;
  localparam int STRB_W      = DATA_W / 8;

  // byte offset bits dropped to form a word address
  localparam int WORD_LSB    = 2;
  localparam int WORD_ADDR_W = AXIL_ADDR_W - WORD_LSB;

  // one read or one write issued toward the banks
  typedef struct packed {
    logic [WORD_ADDR_W-1:0] addr;
    logic                   wr_en;
    logic [DATA_W-1:0]      wr_data;
    logic [STRB_W-1:0]      wr_strb;
  } sram_cmd_t;

  // read data coming back from a bank or the merger
  typedef struct packed {
    logic [DATA_W-1:0] data;
  } sram_rd_t;

endpackage

// ==== source/skid_buf.sv ====
module skid_buf #(
  parameter int WIDTH = 8
) (
  input  logic             clk,
  input  logic             rst_n,

  input  logic             i_valid,
  input  logic [WIDTH-1:0] i_data,
  output logic             o_ready,

  output logic             o_valid,
  output logic [WIDTH-1:0] o_data,
  input  logic             i_ready
);

  logic             skid_valid;
  logic [WIDTH-1:0] skid_data;
  logic             push;
  logic             out_free;

  // ready depends only on the skid flop, never on i_ready
  assign o_ready  = !skid_valid;
  assign push     = i_valid && o_ready;
  assign out_free = !o_valid || i_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_valid    <= 1'b0;
      skid_valid <= 1'b0;
    end else if (out_free) begin
      // skid entry drains first, push cannot happen while it is full
      o_valid    <= skid_valid || push;
      skid_valid <= 1'b0;
    end else if (push) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (out_free) begin
      o_data <= skid_valid ? skid_data : i_data;
    end
    if (push && !out_free) begin
      skid_data <= i_data;
    end
  end

endmodule

// ==== axil_sram_if/axil_sram_if.sv ====
module axil_sram_if import mem_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,

  // AXI-Lite subordinate
  input  logic [AXIL_ADDR_W-1:0] i_awaddr,
  input  logic                   i_awvalid,
  output logic                   o_awready,
  input  logic [DATA_W-1:0]      i_wdata,
  input  logic [STRB_W-1:0]      i_wstrb,
  input  logic                   i_wvalid,
  output logic                   o_wready,
  output logic [1:0]             o_bresp,
  output logic                   o_bvalid,
  input  logic                   i_bready,
  input  logic [AXIL_ADDR_W-1:0] i_araddr,
  input  logic                   i_arvalid,
  output logic                   o_arready,
  output logic [DATA_W-1:0]      o_rdata,
  output logic [1:0]             o_rresp,
  output logic                   o_rvalid,
  input  logic                   i_rready,

  // command toward the banks
  output logic                   o_cmd_valid,
  output sram_cmd_t              o_cmd,
  input  logic                   i_cmd_ready,

  // read data from the merger
  input  logic                   i_rd_valid,
  input  sram_rd_t               i_rd,
  output logic                   o_rd_ready
);

  typedef struct packed {
    logic [STRB_W-1:0] strb;
    logic [DATA_W-1:0] data;
  } w_beat_t;

  logic                   ar_valid;
  logic [WORD_ADDR_W-1:0] ar_addr;
  logic                   aw_valid;
  logic [WORD_ADDR_W-1:0] aw_addr;
  logic                   w_valid;
  w_beat_t                w_in;
  w_beat_t                w_beat;

  logic                   pri_rd;
  logic                   rd_ok;
  logic                   wr_ok;
  logic                   rd_start;
  logic                   wr_start;
  logic                   cmd_free;
  logic                   wr_fire;
  logic                   b_fire;
  logic [1:0]             bcnt;

  skid_buf #(
    .WIDTH(WORD_ADDR_W)
  ) skid_ar_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .i_valid(i_arvalid),
    .i_data (i_araddr[AXIL_ADDR_W-1:WORD_LSB]),
    .o_ready(o_arready),
    .o_valid(ar_valid),
    .o_data (ar_addr),
    .i_ready(rd_start)
  );

  skid_buf #(
    .WIDTH(WORD_ADDR_W)
  ) skid_aw_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .i_valid(i_awvalid),
    .i_data (i_awaddr[AXIL_ADDR_W-1:WORD_LSB]),
    .o_ready(o_awready),
    .o_valid(aw_valid),
    .o_data (aw_addr),
    .i_ready(wr_start)
  );

  // strobes travel with their data
  assign w_in = '{strb: i_wstrb, data: i_wdata};

  skid_buf #(
    .WIDTH($bits(w_beat_t))
  ) skid_w_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .i_valid(i_wvalid),
    .i_data (w_in),
    .o_ready(o_wready),
    .o_valid(w_valid),
    .o_data (w_beat),
    .i_ready(wr_start)
  );

  // read data is already buffered in the merger
  assign o_rdata    = i_rd.data;
  assign o_rvalid   = i_rd_valid;
  assign o_rd_ready = i_rready;
  assign o_rresp    = 2'b00;

  // write responses owed to the manager
  assign wr_fire  = o_cmd_valid && i_cmd_ready && o_cmd.wr_en;
  assign b_fire   = o_bvalid && i_bready;
  assign o_bvalid = (bcnt != 2'd0);
  assign o_bresp  = 2'b00;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bcnt <= 2'd0;
    end else if (wr_fire && !b_fire) begin
      bcnt <= bcnt + 2'd1;
    end else if (b_fire && !wr_fire) begin
      bcnt <= bcnt - 2'd1;
    end
  end

  // alternate priority between reads and writes
  assign cmd_free = !o_cmd_valid || i_cmd_ready;
  assign rd_ok    = ar_valid;
  assign wr_ok    = aw_valid && w_valid && (bcnt < 2'd2);

  always_comb begin
    rd_start = 1'b0;
    wr_start = 1'b0;
    if (cmd_free) begin
      if (rd_ok && (pri_rd || !wr_ok)) begin
        rd_start = 1'b1;
      end else if (wr_ok) begin
        wr_start = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_cmd_valid <= 1'b0;
      pri_rd      <= 1'b0;
    end else begin
      if (cmd_free) begin
        o_cmd_valid <= rd_start || wr_start;
      end
      if (rd_start) begin
        pri_rd <= 1'b0;
      end else if (wr_start) begin
        pri_rd <= 1'b1;
      end
    end
  end

  // command payload
  always_ff @(posedge clk) begin
    if (rd_start) begin
      o_cmd.addr    <= ar_addr;
      o_cmd.wr_en   <= 1'b0;
      o_cmd.wr_strb <= '0;
    end else if (wr_start) begin
      o_cmd.addr    <= aw_addr;
      o_cmd.wr_en   <= 1'b1;
      o_cmd.wr_data <= w_beat.data;
      o_cmd.wr_strb <= w_beat.strb;
    end
  end

endmodule

// ==== source/bank_router.sv ====
module bank_router import mem_pkg::*; #(
  parameter  int NUM_BANKS = 4,
  localparam int BANK_W    = $clog2(NUM_BANKS)
) (
  input  logic                 i_cmd_valid,
  input  sram_cmd_t            i_cmd,
  output logic                 o_cmd_ready,

  input  logic                 i_space,

  output logic [NUM_BANKS-1:0] o_bank_en,
  output sram_cmd_t            o_bank_cmd,

  output logic                 o_rd_issue,
  output logic [BANK_W-1:0]    o_rd_bank
);

  logic              fire;
  logic [BANK_W-1:0] bank;

  // banks never stall, only the merger can hold off commands
  assign o_cmd_ready = i_space;
  assign fire        = i_cmd_valid && i_space;

  // low word address bits pick the bank
  assign bank = i_cmd.addr[BANK_W-1:0];

  assign o_rd_issue = fire && !i_cmd.wr_en;
  assign o_rd_bank  = bank;

  always_comb begin
    o_bank_cmd      = i_cmd;
    // address inside the bank
    o_bank_cmd.addr = i_cmd.addr >> BANK_W;
    o_bank_en       = '0;
    if (fire) begin
      o_bank_en[bank] = 1'b1;
    end
  end

endmodule

// ==== source/sram_bank.sv ====
module sram_bank import mem_pkg::*; #(
  parameter  int DEPTH  = 256,
  localparam int ADDR_W = $clog2(DEPTH)
) (
  input  logic      clk,
  input  logic      rst_n,

  input  logic      i_en,
  input  sram_cmd_t i_cmd,

  output logic      o_rd_valid,
  output sram_rd_t  o_rd
);

  logic [DATA_W-1:0] mem [DEPTH];
  logic [ADDR_W-1:0] idx;
  logic              rd_en;
  logic              wr_en;

  assign idx   = i_cmd.addr[ADDR_W-1:0];
  assign rd_en = i_en && !i_cmd.wr_en;
  assign wr_en = i_en && i_cmd.wr_en;

  // byte lanes written only where the strobe is set
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (i_cmd.wr_strb[b]) begin
          mem[idx][b*8 +: 8] <= i_cmd.wr_data[b*8 +: 8];
        end
      end
    end
    if (rd_en) begin
      o_rd.data <= mem[idx];
    end
  end

  // valid pulse one cycle after the read enable
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_rd_valid <= 1'b0;
    end else begin
      o_rd_valid <= rd_en;
    end
  end

endmodule

// ==== source/resp_merge.sv ====
module resp_merge import mem_pkg::*; #(
  parameter  int NUM_BANKS = 4,
  localparam int BANK_W    = $clog2(NUM_BANKS)
) (
  input  logic                           clk,
  input  logic                           rst_n,

  input  logic                           i_rd_issue,
  input  logic [BANK_W-1:0]              i_rd_bank,

  input  logic [NUM_BANKS-1:0]           i_bank_valid,
  input  sram_rd_t [NUM_BANKS-1:0]       i_bank_rd,

  output logic                           o_rd_valid,
  output sram_rd_t                       o_rd,
  input  logic                           i_rd_ready,

  output logic                           o_space
);

  logic              fly_valid;
  logic [BANK_W-1:0] fly_bank;
  sram_rd_t          fifo_mem [2];
  logic              wr_ptr;
  logic              rd_ptr;
  logic [1:0]        fifo_cnt;
  logic [1:0]        occ;
  logic              push;
  logic              pop;

  // data of the read in flight lands in the FIFO
  assign push = fly_valid && i_bank_valid[fly_bank];
  assign pop  = o_rd_valid && i_rd_ready;

  assign o_rd_valid = (fifo_cnt != 2'd0);
  assign o_rd       = fifo_mem[rd_ptr];

  // in-flight plus buffered reads never exceed two
  assign o_space = (occ < 2'd2);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fly_valid <= 1'b0;
      wr_ptr    <= 1'b0;
      rd_ptr    <= 1'b0;
      fifo_cnt  <= 2'd0;
      occ       <= 2'd0;
    end else begin
      fly_valid <= i_rd_issue;
      wr_ptr    <= wr_ptr ^ push;
      rd_ptr    <= rd_ptr ^ pop;
      fifo_cnt  <= fifo_cnt + {1'b0, push} - {1'b0, pop};
      occ       <= occ + {1'b0, i_rd_issue} - {1'b0, pop};
    end
  end

  always_ff @(posedge clk) begin
    if (i_rd_issue) begin
      fly_bank <= i_rd_bank;
    end
    if (push) begin
      fifo_mem[wr_ptr] <= i_bank_rd[fly_bank];
    end
  end

endmodule

// ==== source/mem_top.sv ====
module mem_top import mem_pkg::*; #(
  parameter int NUM_BANKS = 4
) (
  input  logic                   clk,
  input  logic                   rst_n,

  input  logic [AXIL_ADDR_W-1:0] i_awaddr,
  input  logic                   i_awvalid,
  output logic                   o_awready,
  input  logic [DATA_W-1:0]      i_wdata,
  input  logic [STRB_W-1:0]      i_wstrb,
  input  logic                   i_wvalid,
  output logic                   o_wready,
  output logic [1:0]             o_bresp,
  output logic                   o_bvalid,
  input  logic                   i_bready,
  input  logic [AXIL_ADDR_W-1:0] i_araddr,
  input  logic                   i_arvalid,
  output logic                   o_arready,
  output logic [DATA_W-1:0]      o_rdata,
  output logic [1:0]             o_rresp,
  output logic                   o_rvalid,
  input  logic                   i_rready
);

  localparam int BANK_W     = $clog2(NUM_BANKS);
  localparam int BANK_DEPTH = (1 << WORD_ADDR_W) / NUM_BANKS;

  logic                     cmd_valid;
  sram_cmd_t                cmd;
  logic                     cmd_ready;
  logic                     space;
  logic [NUM_BANKS-1:0]     bank_en;
  sram_cmd_t                bank_cmd;
  logic                     rd_issue;
  logic [BANK_W-1:0]        rd_bank;
  logic [NUM_BANKS-1:0]     bank_valid;
  sram_rd_t [NUM_BANKS-1:0] bank_rd;
  logic                     rd_valid;
  sram_rd_t                 rd;
  logic                     rd_ready;

  axil_sram_if axil_sram_if_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_awaddr   (i_awaddr),
    .i_awvalid  (i_awvalid),
    .o_awready  (o_awready),
    .i_wdata    (i_wdata),
    .i_wstrb    (i_wstrb),
    .i_wvalid   (i_wvalid),
    .o_wready   (o_wready),
    .o_bresp    (o_bresp),
    .o_bvalid   (o_bvalid),
    .i_bready   (i_bready),
    .i_araddr   (i_araddr),
    .i_arvalid  (i_arvalid),
    .o_arready  (o_arready),
    .o_rdata    (o_rdata),
    .o_rresp    (o_rresp),
    .o_rvalid   (o_rvalid),
    .i_rready   (i_rready),
    .o_cmd_valid(cmd_valid),
    .o_cmd      (cmd),
    .i_cmd_ready(cmd_ready),
    .i_rd_valid (rd_valid),
    .i_rd       (rd),
    .o_rd_ready (rd_ready)
  );

  bank_router #(
    .NUM_BANKS(NUM_BANKS)
  ) bank_router_i (
    .i_cmd_valid(cmd_valid),
    .i_cmd      (cmd),
    .o_cmd_ready(cmd_ready),
    .i_space    (space),
    .o_bank_en  (bank_en),
    .o_bank_cmd (bank_cmd),
    .o_rd_issue (rd_issue),
    .o_rd_bank  (rd_bank)
  );

  for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
    sram_bank #(
      .DEPTH(BANK_DEPTH)
    ) sram_bank_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .i_en      (bank_en[i]),
      .i_cmd     (bank_cmd),
      .o_rd_valid(bank_valid[i]),
      .o_rd      (bank_rd[i])
    );
  end

  resp_merge #(
    .NUM_BANKS(NUM_BANKS)
  ) resp_merge_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_rd_issue  (rd_issue),
    .i_rd_bank   (rd_bank),
    .i_bank_valid(bank_valid),
    .i_bank_rd   (bank_rd),
    .o_rd_valid  (rd_valid),
    .o_rd        (rd),
    .i_rd_ready  (rd_ready),
    .o_space     (space)
  );

endmodule

// ==== verif/tb_mem_top.sv ====
module tb_mem_top import mem_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD = 4;
  localparam int NUM_BANKS  = 4;
  localparam int STREAM_OPS = 30;
  localparam int READBACK   = 8;
  // directed phases issue 16 writes and 16 reads each
  localparam int NUM_OPS    = 4 * 16 + 2 * STREAM_OPS + READBACK;

  bit                     clk;
  logic                   rst_n;
  logic [AXIL_ADDR_W-1:0] i_awaddr;
  logic                   i_awvalid;
  logic                   o_awready;
  logic [DATA_W-1:0]      i_wdata;
  logic [STRB_W-1:0]      i_wstrb;
  logic                   i_wvalid;
  logic                   o_wready;
  logic [1:0]             o_bresp;
  logic                   o_bvalid;
  logic                   i_bready;
  logic [AXIL_ADDR_W-1:0] i_araddr;
  logic                   i_arvalid;
  logic                   o_arready;
  logic [DATA_W-1:0]      o_rdata;
  logic [1:0]             o_rresp;
  logic                   o_rvalid;
  logic                   i_rready;

  logic [31:0]            lfsr = 32'h7fe8;
  logic [DATA_W-1:0]      model [int];
  logic [DATA_W-1:0]      exp_q [$];
  logic [DATA_W-1:0]      exp_head;
  int                     exp_count;
  logic [WORD_ADDR_W-1:0] written [$];
  logic [WORD_ADDR_W-1:0] stream_addrs [$];
  int                     wr_count;
  int                     rd_count;
  int                     b_count;
  int                     r_count;
  logic                   check_reset;
  logic                   stall_en;
  logic [4:0]             port_state;

  mem_top #(
    .NUM_BANKS(NUM_BANKS)
  ) mem_top_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_awaddr (i_awaddr),
    .i_awvalid(i_awvalid),
    .o_awready(o_awready),
    .i_wdata  (i_wdata),
    .i_wstrb  (i_wstrb),
    .i_wvalid (i_wvalid),
    .o_wready (o_wready),
    .o_bresp  (o_bresp),
    .o_bvalid (o_bvalid),
    .i_bready (i_bready),
    .i_araddr (i_araddr),
    .i_arvalid(i_arvalid),
    .o_arready(o_arready),
    .o_rdata  (o_rdata),
    .o_rresp  (o_rresp),
    .o_rvalid (o_rvalid),
    .i_rready (i_rready)
  );

  initial begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one LFSR step per bit taken
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic void apply_write(logic [WORD_ADDR_W-1:0] waddr, logic [31:0] data,
                                      logic [3:0] strb);
    logic [31:0] word;
    word = model.exists(waddr) ? model[waddr] : '0;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        word[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    model[waddr] = word;
  endfunction

  function automatic void update_head();
    exp_count = exp_q.size();
    exp_head  = (exp_q.size() > 0) ? exp_q[0] : 'x;
  endfunction

  task automatic stop_run(string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
    stop_run($sformatf("MISMATCH time=%0t %s expected=0x%h actual=0x%h",
                       $time, name, expected, actual));
  endtask

  // entered and left 1 ns after a rising edge
  task automatic send_write(logic [WORD_ADDR_W-1:0] waddr, logic [31:0] data,
                            logic [3:0] strb);
    logic aw_done;
    logic w_done;
    aw_done = 1'b0;
    w_done  = 1'b0;
    apply_write(waddr, data, strb);
    i_awaddr  = {waddr, 2'b00};
    i_awvalid = 1'b1;
    i_wdata   = data;
    i_wstrb   = strb;
    i_wvalid  = 1'b1;
    while (!(aw_done && w_done)) begin
      @(negedge clk);
      // transfer happens at the next rising edge
      if (i_awvalid && o_awready) begin
        aw_done = 1'b1;
        wr_count++;
      end
      if (i_wvalid && o_wready) begin
        w_done = 1'b1;
      end
      @(posedge clk);
      #1;
      if (aw_done) begin
        i_awvalid = 1'b0;
      end
      if (w_done) begin
        i_wvalid = 1'b0;
      end
    end
  endtask

  task automatic send_read(logic [WORD_ADDR_W-1:0] waddr);
    logic done;
    done      = 1'b0;
    i_araddr  = {waddr, 2'b00};
    i_arvalid = 1'b1;
    while (!done) begin
      @(negedge clk);
      if (o_arready) begin
        done = 1'b1;
        rd_count++;
        exp_q.push_back(model[waddr]);
        update_head();
      end
      @(posedge clk);
      #1;
    end
    i_arvalid = 1'b0;
  endtask

  task automatic wait_idle();
    while (b_count != wr_count || r_count != rd_count) begin
      @(posedge clk);
      #1;
    end
  endtask

  // count responses at the falling edge where the ports are stable
  always @(negedge clk) begin
    if (rst_n && o_bvalid && i_bready) begin
      b_count++;
    end
    if (rst_n && o_rvalid && i_rready) begin
      r_count++;
      if (exp_q.size() > 0) begin
        void'(exp_q.pop_front());
      end
      update_head();
    end
  end

  assign port_state = {o_bvalid, o_rvalid, o_arready, o_awready, o_wready};

  reset_state_check: assert property (@(negedge clk)
    check_reset |-> (port_state == 5'b00111))
    else report_mismatch("bvalid,rvalid,arready,awready,wready", 32'h7,
                         32'($sampled(port_state)));

  bresp_check: assert property (@(negedge clk) disable iff (!rst_n)
    (o_bvalid && i_bready) |-> (o_bresp == 2'b00))
    else report_mismatch("o_bresp", 32'h0, 32'($sampled(o_bresp)));

  rresp_check: assert property (@(negedge clk) disable iff (!rst_n)
    (o_rvalid && i_rready) |-> (o_rresp == 2'b00))
    else report_mismatch("o_rresp", 32'h0, 32'($sampled(o_rresp)));

  rdata_check: assert property (@(negedge clk) disable iff (!rst_n)
    (o_rvalid && i_rready) |-> (o_rdata == exp_head))
    else report_mismatch("o_rdata", $sampled(exp_head), $sampled(o_rdata));

  extra_r_check: assert property (@(negedge clk) disable iff (!rst_n)
    (o_rvalid && i_rready) |-> (exp_count != 0))
    else stop_run("read response arrived with no read outstanding");

  extra_b_check: assert property (@(negedge clk) disable iff (!rst_n)
    (o_bvalid && i_bready) |-> (b_count < wr_count))
    else stop_run("write response arrived with no write outstanding");

  // random response stalls while enabled
  initial begin
    i_rready = 1'b1;
    i_bready = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      i_rready = stall_en ? (rand_bits(1) != 0) : 1'b1;
      i_bready = stall_en ? (rand_bits(1) != 0) : 1'b1;
    end
  end

  initial begin
    #(NUM_OPS * 40 * CLK_PERIOD);
    stop_run("timeout: the test did not finish within the expected number of cycles");
  end

  initial begin
    logic [31:0]            r;
    logic [31:0]            d;
    logic [WORD_ADDR_W-1:0] w;
    rst_n       = 1'b0;
    i_awaddr    = '0;
    i_awvalid   = 1'b0;
    i_wdata     = '0;
    i_wstrb     = '0;
    i_wvalid    = 1'b0;
    i_araddr    = '0;
    i_arvalid   = 1'b0;
    check_reset = 1'b1;
    stall_en    = 1'b0;
    update_head();
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // port state is also checked on the first cycle out of reset
    @(negedge clk);
    #1;
    check_reset = 1'b0;
    @(posedge clk);
    #1;

    // low address bits walk every bank, bit 9 clear
    for (int k = 0; k < 16; k++) begin
      r = rand_bits(5);
      w = {1'b0, r[4:0], k[3:0]};
      d = rand_bits(32);
      send_write(w, d, 4'hf);
      wait_idle();
      send_read(w);
      wait_idle();
      written.push_back(w);
    end

    // partial strobes over known words
    for (int k = 0; k < 16; k++) begin
      r = rand_bits(4);
      w = written[r[3:0]];
      d = rand_bits(32);
      r = rand_bits(4);
      send_write(w, d, r[3:0]);
      wait_idle();
      send_read(w);
      wait_idle();
    end

    // writes to the upper half never touch the words being read
    stall_en = 1'b1;
    fork
      begin : writer
        logic [31:0]            wr_r;
        logic [WORD_ADDR_W-1:0] wr_w;
        for (int n = 0; n < STREAM_OPS; n++) begin
          wr_r = rand_bits(9);
          wr_w = {1'b1, wr_r[8:0]};
          wr_r = rand_bits(32);
          send_write(wr_w, wr_r, 4'hf);
          stream_addrs.push_back(wr_w);
        end
      end
      begin : reader
        logic [31:0] rd_r;
        for (int n = 0; n < STREAM_OPS; n++) begin
          rd_r = rand_bits(4);
          send_read(written[rd_r[3:0]]);
        end
      end
    join
    stall_en = 1'b0;
    wait_idle();

    for (int k = 0; k < READBACK; k++) begin
      send_read(stream_addrs[stream_addrs.size() - 1 - k]);
    end
    wait_idle();

    @(negedge clk);
    @(posedge clk);
    #1;
    $display("All tests passed");
    $finish;
  end

endmodule

// ==== verilog.f ====
common/mem_pkg.sv
source/skid_buf.sv
axil_sram_if/axil_sram_if.sv
source/bank_router.sv
source/sram_bank.sv
source/resp_merge.sv
source/mem_top.sv
verif/tb_mem_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mem_top
LINT_TOP  ?= mem_top
FILE_LIST ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert --timescale $(TIMESCALE)
PASS_MSG  ?= All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --timescale $(TIMESCALE) -f $(FILE_LIST) \
		--top-module $(LINT_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
